//--- source/axi_lite_pkg.sv
// AXI4-Lite bus types
package axi_lite_pkg;

  typedef logic [7:0]  axi_addr_t;   // Byte address
  typedef logic [31:0] axi_data_t;
  typedef logic [3:0]  axi_strb_t;   // One strobe per byte lane

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  // Write address channel, host to slave
  typedef struct packed {
    axi_addr_t addr;
    logic      valid;
  } axil_aw_t;

  // Write data channel, host to slave
  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      valid;
  } axil_w_t;

  // Write response channel, slave to host
  typedef struct packed {
    axi_resp_e resp;
    logic      valid;
  } axil_b_t;

  // Read address channel, host to slave
  typedef struct packed {
    axi_addr_t addr;
    logic      valid;
  } axil_ar_t;

  // Read data channel, slave to host
  typedef struct packed {
    axi_data_t data;
    axi_resp_e resp;
    logic      valid;
  } axil_r_t;

endpackage

//--- source/regfile_pkg.sv
// Register file types and address map
package regfile_pkg;

  localparam int rf_idx_w    = 3;
  localparam int rf_max_regs = 1 << rf_idx_w;  // Largest count the index can reach

  typedef logic [rf_idx_w-1:0] reg_idx_t;
  typedef logic [7:0]          reg_data_t;
  typedef logic [8:0]          reg_sum_t;    // Room for the carry out of bit 7

  // Address map
  // Write: register index in address bits 4..2, data byte in data bits 7..0
  // Read:  index A in address bits 4..2, index B in address bits 7..5
  localparam int addr_wr_idx_lsb = 2;
  localparam int addr_rd_a_lsb   = 2;
  localparam int addr_rd_b_lsb   = 5;

  // One write request per accepted bus write
  typedef struct packed {
    logic      en;
    reg_idx_t  idx;
    reg_data_t data;
  } rf_write_t;

  // Read data word returned to the host
  // Bits 31..25 stay zero
  typedef struct packed {
    logic [6:0] pad;
    reg_sum_t   sum;   // Bits 24..16
    reg_data_t  b;     // Bits 15..8
    reg_data_t  a;     // Bits 7..0
  } rf_rd_word_t;

endpackage

//--- source/axil_write_front.sv
// AXI4-Lite write front end
module axil_write_front
  import axi_lite_pkg::*;
  import regfile_pkg::*;
#(
  parameter int num_regs = rf_max_regs
) (
  input  logic      clk,
  input  logic      rst,
  input  axil_aw_t  aw,
  input  axil_w_t   w,
  output logic      awready,
  output logic      wready,
  output axil_b_t   b,
  input  logic      bready,
  output rf_write_t rf_wr
);

  typedef enum logic {
    IDLE,
    RESP
  } state_e;

  state_e    state;
  logic      accept;
  reg_idx_t  wr_idx;
  logic      idx_ok;
  axi_resp_e resp_q;

  // Address and data must arrive together, one write in flight
  assign accept = (state == IDLE) && aw.valid && w.valid;

  assign awready = accept;
  assign wready  = accept;

  assign wr_idx = aw.addr[addr_wr_idx_lsb +: rf_idx_w];
  assign idx_ok = int'(wr_idx) < num_regs;

  // Request to the register file in the accept cycle
  // Only lane 0 is implemented, so strobe bit 0 decides the store
  always_comb begin
    rf_wr.en   = accept && idx_ok && w.strb[0];
    rf_wr.idx  = wr_idx;
    rf_wr.data = w.data[7:0];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            state <= RESP;
          end
        end
        RESP: begin
          if (bready) begin
            state <= IDLE;   // Host took the response
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Response code captured with the accepted write
  always_ff @(posedge clk) begin
    if (accept) begin
      resp_q <= idx_ok ? OKAY : SLVERR;
    end
  end

  always_comb begin
    b.valid = (state == RESP);
    b.resp  = resp_q;
  end

endmodule

//--- source/register_file.sv
// Dual read port register file
module register_file
  import regfile_pkg::*;
#(
  parameter int num_regs = rf_max_regs
) (
  input  logic      clk,
  input  logic      rst,
  input  rf_write_t rf_wr,
  input  reg_idx_t  rd1_idx,
  input  reg_idx_t  rd2_idx,
  output reg_data_t rd1_data,
  output reg_data_t rd2_data
);

  if (num_regs < 1 || num_regs > rf_max_regs) begin : g_bad_count
    $error("num_regs must be between 1 and %0d", rf_max_regs);
  end

  reg_data_t regs [num_regs];

  // Storage, cleared on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_wr.en && int'(rf_wr.idx) < num_regs) begin
      regs[rf_wr.idx] <= rf_wr.data;
    end
  end

  // Combinational reads, old value during a write cycle
  // Unimplemented entries read as zero
  always_comb begin
    rd1_data = '0;
    rd2_data = '0;
    if (int'(rd1_idx) < num_regs) begin
      rd1_data = regs[rd1_idx];
    end
    if (int'(rd2_idx) < num_regs) begin
      rd2_data = regs[rd2_idx];
    end
  end

endmodule

//--- source/operand_read_unit.sv
// AXI4-Lite operand read unit
module operand_read_unit
  import axi_lite_pkg::*;
  import regfile_pkg::*;
#(
  parameter int num_regs = rf_max_regs
) (
  input  logic      clk,
  input  logic      rst,
  input  axil_ar_t  ar,
  output logic      arready,
  output axil_r_t   r,
  input  logic      rready,
  output reg_idx_t  rd1_idx,
  output reg_idx_t  rd2_idx,
  input  reg_data_t rd1_data,
  input  reg_data_t rd2_data
);

  typedef enum logic {
    IDLE,
    RESP
  } state_e;

  state_e      state;
  logic        accept;
  logic        a_ok;
  logic        b_ok;
  reg_sum_t    sum;
  rf_rd_word_t word;
  axi_data_t   data_q;
  axi_resp_e   resp_q;

  assign accept  = (state == IDLE) && ar.valid;
  assign arready = accept;

  // Both indices come straight from the read address
  assign rd1_idx = ar.addr[addr_rd_a_lsb +: rf_idx_w];
  assign rd2_idx = ar.addr[addr_rd_b_lsb +: rf_idx_w];

  assign a_ok = int'(rd1_idx) < num_regs;
  assign b_ok = int'(rd2_idx) < num_regs;

  // Zero-extend so the carry lands in bit 8
  assign sum = {1'b0, rd1_data} + {1'b0, rd2_data};

  always_comb begin
    word     = '0;
    word.a   = rd1_data;
    word.b   = rd2_data;
    word.sum = sum;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            state <= RESP;
          end
        end
        RESP: begin
          if (rready) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Result captured in the accept cycle, held until rready
  always_ff @(posedge clk) begin
    if (accept) begin
      if (a_ok && b_ok) begin
        data_q <= axi_data_t'(word);
        resp_q <= OKAY;
      end else begin
        data_q <= '0;        // No data on a range error
        resp_q <= SLVERR;
      end
    end
  end

  always_comb begin
    r.valid = (state == RESP);
    r.resp  = resp_q;
    r.data  = data_q;
  end

endmodule

//--- source/regfile_subsystem.sv
// Register file subsystem top level
module regfile_subsystem
  import axi_lite_pkg::*;
  import regfile_pkg::*;
#(
  parameter int num_regs = 8
) (
  input  logic     clk,
  input  logic     rst,
  input  axil_aw_t aw,
  input  axil_w_t  w,
  output logic     awready,
  output logic     wready,
  output axil_b_t  b,
  input  logic     bready,
  input  axil_ar_t ar,
  output logic     arready,
  output axil_r_t  r,
  input  logic     rready
);

  rf_write_t rf_wr;      // Write front to register file
  reg_idx_t  rd1_idx;
  reg_idx_t  rd2_idx;
  reg_data_t rd1_data;
  reg_data_t rd2_data;

  axil_write_front #(
    .num_regs(num_regs)
  ) axil_write_front_inst (
    .clk    (clk),
    .rst    (rst),
    .aw     (aw),
    .w      (w),
    .awready(awready),
    .wready (wready),
    .b      (b),
    .bready (bready),
    .rf_wr  (rf_wr)
  );

  register_file #(
    .num_regs(num_regs)
  ) register_file_inst (
    .clk     (clk),
    .rst     (rst),
    .rf_wr   (rf_wr),
    .rd1_idx (rd1_idx),
    .rd2_idx (rd2_idx),
    .rd1_data(rd1_data),
    .rd2_data(rd2_data)
  );

  // Read side serves the AXI4-Lite read channel
  operand_read_unit #(
    .num_regs(num_regs)
  ) operand_read_unit_inst (
    .clk     (clk),
    .rst     (rst),
    .ar      (ar),
    .arready (arready),
    .r       (r),
    .rready  (rready),
    .rd1_idx (rd1_idx),
    .rd2_idx (rd2_idx),
    .rd1_data(rd1_data),
    .rd2_data(rd2_data)
  );

endmodule

//--- sim/tb_clock_gen.sv
// Testbench clock source
module tb_clock_gen #(
  parameter int period = 8
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

endmodule

//--- sim/register_file_checker.sv
// Register file assertions
module register_file_checker
  import regfile_pkg::*;
#(
  parameter int num_regs = rf_max_regs
) (
  input logic      clk,
  input logic      rst,
  input rf_write_t rf_wr,
  input reg_idx_t  rd1_idx,
  input reg_idx_t  rd2_idx,
  input reg_data_t rd1_data,
  input reg_data_t rd2_data
);

  reg_data_t shadow [rf_max_regs];   // Expected contents
  reg_data_t exp1;
  reg_data_t exp2;
  bit        x_fail     = 1'b0;
  bit        model_fail = 1'b0;
  bit        agree_fail = 1'b0;
  bit        range_fail = 1'b0;
  logic      failed;

  assign failed = x_fail | model_fail | agree_fail | range_fail;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rf_max_regs; i++) begin
        shadow[i] <= '0;
      end
    end else if (rf_wr.en && int'(rf_wr.idx) < num_regs) begin
      shadow[rf_wr.idx] <= rf_wr.data;
    end
  end

  // Unimplemented entries are expected to read zero
  always_comb begin
    exp1 = (int'(rd1_idx) < num_regs) ? shadow[rd1_idx] : '0;
    exp2 = (int'(rd2_idx) < num_regs) ? shadow[rd2_idx] : '0;
  end

  assert property (@(posedge clk) disable iff (rst) !$isunknown(rf_wr.en))
    else begin
      x_fail = 1'b1;
      $error("register file write enable is unknown");
    end

  assert property (@(posedge clk) disable iff (rst)
    rf_wr.en |=> (rd1_data == exp1) && (rd2_data == exp2))
    else begin
      model_fail = 1'b1;
      $error("read data differs from the shadow contents after a write");
    end

  assert property (@(posedge clk) disable iff (rst)
    (rd1_idx == rd2_idx) |-> (rd1_data == rd2_data))
    else begin
      agree_fail = 1'b1;
      $error("read ports disagree on the same index");
    end

  assert property (@(posedge clk) disable iff (rst)
    (int'(rd1_idx) < num_regs || rd1_data == '0) &&
    (int'(rd2_idx) < num_regs || rd2_data == '0))
    else begin
      range_fail = 1'b1;
      $error("unimplemented register reads nonzero");
    end

endmodule

bind register_file register_file_checker #(
  .num_regs(num_regs)
) register_file_checker_inst (
  .clk     (clk),
  .rst     (rst),
  .rf_wr   (rf_wr),
  .rd1_idx (rd1_idx),
  .rd2_idx (rd2_idx),
  .rd1_data(rd1_data),
  .rd2_data(rd2_data)
);

//--- sim/regfile_subsystem_tb.sv
// Register file subsystem testbench
module regfile_subsystem_tb
  import axi_lite_pkg::*;
  import regfile_pkg::*;
();

  localparam int num_regs     = 6;    // Leaves indices 6 and 7 unimplemented
  localparam int reset_cycles = 16;
  localparam int txn_cycles   = 40;   // Allowance per bus transaction

  logic      clk;
  logic      rst;
  axil_aw_t  aw;
  axil_w_t   w;
  logic      awready;
  logic      wready;
  axil_b_t   b;
  logic      bready;
  axil_ar_t  ar;
  logic      arready;
  axil_r_t   r;
  logic      rready;
  reg_data_t ref_regs [rf_max_regs];  // Reference register contents
  int        issued = 0;
  int        seed   = 32'hbf20;

  tb_clock_gen #(.period(8)) tb_clock_gen_inst (.clk(clk));

  regfile_subsystem #(.num_regs(num_regs)) regfile_subsystem_inst (.*);

  task automatic fail_run();
    $display("TEST FAIL");
    $fatal(1, "run stopped on failure");
  endtask

  task automatic check_resp(input axi_resp_e got, input axi_resp_e exp, input string what);
    if (got !== exp) begin
      $display("error %0t: %s response %s, expected %s", $time, what, got.name(), exp.name());
      fail_run();
    end
  endtask

  task automatic check_data(input reg_data_t got, input reg_data_t exp, input string what);
    if (got !== exp) begin
      $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
      fail_run();
    end
  endtask

  task automatic check_sum(input reg_sum_t got, input reg_sum_t exp, input string what);
    if (got !== exp) begin
      $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
      fail_run();
    end
  endtask

  task automatic start_write(input reg_idx_t idx, input reg_data_t data, input logic strb0);
    issued++;
    @(posedge clk);
    aw <= '{addr: {3'b000, idx, 2'b00}, valid: 1'b1};
    w  <= '{data: {24'h0, data}, strb: {3'b000, strb0}, valid: 1'b1};
  endtask

  task automatic wait_write_accept();
    do begin
      @(posedge clk);
    end while (!(awready && wready));
    aw.valid <= 1'b0;
    w.valid  <= 1'b0;
  endtask

  // Takes B and updates the reference on a write that should land
  task automatic take_write_resp(input reg_idx_t idx, input reg_data_t data, input logic strb0);
    axi_resp_e exp;
    exp = (int'(idx) < num_regs) ? OKAY : SLVERR;
    do begin
      @(posedge clk);
    end while (!(b.valid && bready));
    check_resp(b.resp, exp, "write");
    if (exp == OKAY && strb0) begin
      ref_regs[idx] = data;
    end
  endtask

  task automatic write_reg(input reg_idx_t idx, input reg_data_t data, input logic strb0);
    start_write(idx, data, strb0);
    wait_write_accept();
    take_write_resp(idx, data, strb0);
  endtask

  task automatic start_read(input reg_idx_t ia, input reg_idx_t ib);
    issued++;
    @(posedge clk);
    ar <= '{addr: {ib, ia, 2'b00}, valid: 1'b1};
  endtask

  task automatic wait_read_accept();
    do begin
      @(posedge clk);
    end while (!arready);
    ar.valid <= 1'b0;
  endtask

  task automatic take_read_resp(input reg_idx_t ia, input reg_idx_t ib);
    logic     ok;
    reg_sum_t sum;
    ok  = int'(ia) < num_regs && int'(ib) < num_regs;
    sum = ok ? reg_sum_t'(ref_regs[ia]) + reg_sum_t'(ref_regs[ib]) : '0;
    do begin
      @(posedge clk);
    end while (!(r.valid && rready));
    check_resp(r.resp, ok ? OKAY : SLVERR, "read");
    check_data(r.data[7:0], ok ? ref_regs[ia] : '0, "register A");
    check_data(r.data[15:8], ok ? ref_regs[ib] : '0, "register B");
    check_sum(r.data[24:16], sum, "sum");
    check_data(reg_data_t'(r.data[31:25]), '0, "upper read bits");
  endtask

  task automatic read_pair(input reg_idx_t ia, input reg_idx_t ib);
    start_read(ia, ib);
    wait_read_accept();
    take_read_resp(ia, ib);
  endtask

  task automatic test_reset_state();
    for (int ia = 0; ia < num_regs; ia++) begin
      for (int ib = 0; ib < num_regs; ib++) begin
        read_pair(reg_idx_t'(ia), reg_idx_t'(ib));
      end
    end
  endtask

  task automatic test_write_readback();
    for (int i = 0; i < num_regs; i++) begin
      write_reg(reg_idx_t'(i), reg_data_t'($random(seed)), 1'b1);
      read_pair(reg_idx_t'(i), reg_idx_t'((i + 1) % num_regs));
    end
    write_reg(3'd4, 8'hf0, 1'b1);   // Pair 4 and 5 carries into bit 8
    write_reg(3'd5, 8'h9c, 1'b1);
    read_pair(3'd4, 3'd5);
    for (int i = 0; i < num_regs; i++) begin
      read_pair(reg_idx_t'(i), reg_idx_t'(num_regs - 1 - i));
    end
  endtask

  task automatic test_same_index();
    for (int i = 0; i < num_regs; i++) begin
      read_pair(reg_idx_t'(i), reg_idx_t'(i));
    end
  endtask

  task automatic test_range_errors();
    write_reg(3'd6, 8'h5a, 1'b1);
    write_reg(3'd7, 8'ha5, 1'b1);
    read_pair(3'd6, 3'd0);
    read_pair(3'd1, 3'd7);
    read_pair(3'd7, 3'd6);
    test_same_index();              // Nothing implemented has moved
  endtask

  task automatic test_strobe_off();
    write_reg(3'd2, ~ref_regs[2], 1'b0);
    read_pair(3'd2, 3'd2);
    read_pair(3'd2, 3'd0);
  endtask

  task automatic test_back_pressure();
    reg_data_t d1;
    reg_data_t d2;
    d1 = reg_data_t'($random(seed));
    d2 = reg_data_t'($random(seed));
    @(posedge clk);
    bready <= 1'b0;
    rready <= 1'b0;
    start_write(3'd1, d1, 1'b1);
    wait_write_accept();
    start_write(3'd3, d2, 1'b1);
    repeat (5) begin
      @(posedge clk);
      if (awready || wready) begin
        $display("second write was accepted while the first response was held");
        fail_run();
      end
    end
    bready <= 1'b1;
    take_write_resp(3'd1, d1, 1'b1);
    wait_write_accept();
    take_write_resp(3'd3, d2, 1'b1);
    start_read(3'd1, 3'd1);
    wait_read_accept();
    start_read(3'd3, 3'd1);
    repeat (5) begin
      @(posedge clk);
      if (arready) begin
        $display("second read was accepted while the first response was held");
        fail_run();
      end
    end
    rready <= 1'b1;
    take_read_resp(3'd1, 3'd1);
    wait_read_accept();
    take_read_resp(3'd3, 3'd1);
  endtask

  // Limit grows with every transaction issued
  initial begin : watchdog
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > reset_cycles + txn_cycles * (issued + 1)) begin
        $display("simulation timed out");
        fail_run();
      end
    end
  end

  // A bound assertion failure ends the run at once
  initial begin : assertion_monitor
    @(posedge regfile_subsystem_inst.register_file_inst.register_file_checker_inst.failed);
    $display("a register file assertion failed");
    fail_run();
  end

  initial begin
    rst    = 1'b1;
    aw     = '0;
    w      = '0;
    ar     = '0;
    bready = 1'b1;
    rready = 1'b1;
    foreach (ref_regs[i]) begin
      ref_regs[i] = '0;
    end
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
    test_reset_state();
    test_write_readback();
    test_same_index();
    test_range_errors();
    test_strobe_off();
    test_back_pressure();
    repeat (2) @(posedge clk);
    if (regfile_subsystem_inst.register_file_inst.register_file_checker_inst.failed) begin
      $display("a register file assertion failed during the run");
      fail_run();
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

//--- src.f
source/axi_lite_pkg.sv
source/regfile_pkg.sv
source/axil_write_front.sv
source/register_file.sv
source/operand_read_unit.sv
source/regfile_subsystem.sv
sim/tb_clock_gen.sv
sim/register_file_checker.sv
sim/regfile_subsystem_tb.sv

//--- Makefile
# Verilator build and run for the register file subsystem
TOP := regfile_subsystem_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
